//--- logic/lsu_pkg.sv
// Sizes are fixed here for one rename bit and one dispatch and one writeback per cycle
package lsu_pkg;

	// Operand and physical register sizes
	localparam int xlen = 64;
	localparam int rb = 1;
	localparam int preg_w = 5 + rb;
	localparam int preg_num = 1 << preg_w;

	// Queue depths and their index widths
	localparam int lu_dp = 4;
	localparam int su_dp = 4;
	localparam int lu_iw = $clog2(lu_dp);
	localparam int su_pw = $clog2(su_dp);

	// Read ports: one per load slot, then store rs1 and store rs2
	localparam int rp_num = lu_dp + 2;
	localparam int su_rs1_port = lu_dp;
	localparam int su_rs2_port = lu_dp + 1;

	// Access size, one-hot
	typedef struct packed {
		logic b;
		logic h;
		logic w;
		logic d;
	} mem_size_t;

	typedef struct packed {
		logic lb;
		logic lh;
		logic lw;
		logic ld;
		logic lbu;
		logic lhu;
		logic lwu;
		logic [xlen-1:0] imm;
		logic [preg_w-1:0] rd;
		logic [preg_w-1:0] rs1;
	} lu_info_t;

	// Store op one-hot doubles as the access size
	typedef struct packed {
		mem_size_t op;
		logic [xlen-1:0] imm;
		logic [preg_w-1:0] rs1;
		logic [preg_w-1:0] rs2;
		logic [2:0] pad;
	} su_info_t;

	// One dispatch word, read as a load or as a store
	typedef union packed {
		lu_info_t lu;
		su_info_t su;
	} issue_info_u;

	typedef struct packed {
		logic is_store;
		issue_info_u info;
	} dispatch_t;

	typedef struct packed {
		mem_size_t size;
		logic [preg_w-1:0] rd;
		logic [xlen-1:0] addr;
		logic usi;
	} lu_exeparam_t;

	typedef struct packed {
		mem_size_t size;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
	} su_exeparam_t;

	typedef struct packed {
		logic [preg_w-1:0] idx;
		logic [xlen-1:0] data;
	} wb_t;

	// Architectural x0 of any rename copy
	function automatic logic is_x0(input logic [preg_w-1:0] idx);
		return idx[preg_w-1:rb] == '0;
	endfunction

endpackage

//--- logic/first_clear_select.sv
// Priority from index 0 upward; width must be at least two
`timescale 1ns/1ns

module first_clear_select #(
	parameter int width = 4
) (
	input  logic [width-1:0] req,
	output logic [$clog2(width)-1:0] pos,
	output logic any
);
	localparam int pw = $clog2(width);

	// Scan downward so the lowest set bit is written last
	always_comb begin
		pos = '0;
		for (int i = width - 1; i >= 0; i--) begin
			if (req[i]) begin
				pos = pw'(i);
			end
		end
	end

	// Pos is zero and meaningless when nothing is set
	assign any = |req;

endmodule

//--- logic/phy_regfile.sv
// Reads are combinational and x0 of every rename copy reads zero; values have no reset
`timescale 1ns/1ns

module phy_regfile (
	input  logic CLK,
	input  logic rst,
	input  logic wb_valid,
	input  lsu_pkg::wb_t wb,
	input  logic alloc_valid,
	input  logic [lsu_pkg::preg_w-1:0] alloc_preg,
	input  logic [lsu_pkg::rp_num-1:0][lsu_pkg::preg_w-1:0] rd_idx,
	output logic [lsu_pkg::rp_num-1:0][lsu_pkg::xlen-1:0] rd_data,
	output logic [lsu_pkg::rp_num-1:0] rd_done
);
	import lsu_pkg::*;

	logic [xlen-1:0] regs [preg_num];
	// Written-back log, one bit per physical register
	logic [preg_num-1:0] wb_log;

	// Register values
	always_ff @(posedge CLK) begin
		if (wb_valid) begin
			regs[wb.idx] <= wb.data;
		end
	end

	// Log starts all done
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_log <= '1;
		end else begin
			// Load dispatch marks its rd pending
			if (alloc_valid) begin
				wb_log[alloc_preg] <= 1'b0;
			end
			// Later statement, so writeback wins a same-register clash
			if (wb_valid) begin
				wb_log[wb.idx] <= 1'b1;
			end
		end
	end

	// Read ports
	always_comb begin
		for (int i = 0; i < rp_num; i++) begin
			rd_data[i] = is_x0(rd_idx[i]) ? '0 : regs[rd_idx[i]];
			rd_done[i] = wb_log[rd_idx[i]];
		end
	end

endmodule

//--- logic/lu_issue_buffer.sv
// Unordered load slots; caller must not push when full, pop index must name a live slot
`timescale 1ns/1ns

module lu_issue_buffer (
	input  logic CLK,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  lsu_pkg::lu_info_t push_info,
	input  logic pop,
	input  logic [lsu_pkg::lu_iw-1:0] pop_index,
	output logic [lsu_pkg::lu_dp-1:0] malloc,
	output lsu_pkg::lu_info_t [lsu_pkg::lu_dp-1:0] slots,
	output logic full
);
	import lsu_pkg::*;

	logic [lu_iw-1:0] free_pos;
	logic free_any;
	logic do_push;

	// Lowest free slot
	first_clear_select #(
		.width(lu_dp)
	) u_free (
		.req(~malloc),
		.pos(free_pos),
		.any(free_any)
	);

	assign full = ~free_any;
	assign do_push = push & free_any;

	// Allocation bits
	always_ff @(posedge CLK) begin
		if (rst | flush) begin
			malloc <= '0;
		end else begin
			// Pushed slot is free, popped one is live, never the same
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (do_push) begin
				malloc[free_pos] <= 1'b1;
			end
		end
	end

	// Slot payload
	always_ff @(posedge CLK) begin
		if (do_push) begin
			slots[free_pos] <= push_info;
		end
	end

endmodule

//--- logic/su_issue_fifo.sv
// Strict in-order store queue; head is only meaningful while not empty
`timescale 1ns/1ns

module su_issue_fifo (
	input  logic CLK,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  lsu_pkg::su_info_t push_info,
	input  logic pop,
	output lsu_pkg::su_info_t head,
	output logic empty,
	output logic full
);
	import lsu_pkg::*;

	su_info_t mem [su_dp];
	logic [su_pw-1:0] rd_ptr;
	logic [su_pw-1:0] wr_ptr;
	// One bit wider than the pointers to tell full from empty
	logic [su_pw:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// Pointers and occupancy
	always_ff @(posedge CLK) begin
		if (rst | flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			rd_ptr <= rd_ptr + su_pw'(do_pop);
			wr_ptr <= wr_ptr + su_pw'(do_push);
			count <= count + (su_pw + 1)'(do_push) - (su_pw + 1)'(do_pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_info;
		end
	end

	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (su_pw + 1)'(su_dp));

endmodule

//--- logic/lsu_issue.sv
// No load/store ordering and no exceptions; both outputs are registered and flush drops them
`timescale 1ns/1ns

module lsu_issue (
	input  logic CLK,
	input  logic rst,
	input  logic flush,
	input  logic [lsu_pkg::lu_dp-1:0] malloc,
	input  lsu_pkg::lu_info_t [lsu_pkg::lu_dp-1:0] slots,
	input  lsu_pkg::su_info_t su_head,
	input  logic su_empty,
	input  logic [lsu_pkg::rp_num-1:0][lsu_pkg::xlen-1:0] rf_data,
	input  logic [lsu_pkg::rp_num-1:0] rf_done,
	input  logic lu_exeparam_ready,
	input  logic su_exeparam_ready,
	input  logic commit_store_ready,
	output logic [lsu_pkg::rp_num-1:0][lsu_pkg::preg_w-1:0] rf_idx,
	output logic lu_pop,
	output logic [lsu_pkg::lu_iw-1:0] lu_pop_index,
	output logic lu_exeparam_valid,
	output lsu_pkg::lu_exeparam_t lu_exeparam,
	output logic su_pop,
	output logic su_exeparam_valid,
	output lsu_pkg::su_exeparam_t su_exeparam
);
	import lsu_pkg::*;

	logic [lu_dp-1:0] lu_ready;
	lu_exeparam_t [lu_dp-1:0] lu_param;
	logic lu_any;
	logic su_rs1_ok;
	logic su_rs2_ok;
	logic su_clear;

	// Read port map: slot rs1s first, then store head operands
	always_comb begin
		for (int i = 0; i < lu_dp; i++) begin
			rf_idx[i] = slots[i].rs1;
		end
		rf_idx[su_rs1_port] = su_head.rs1;
		rf_idx[su_rs2_port] = su_head.rs2;
	end

	// Per-slot readiness and execution parameters
	always_comb begin
		for (int i = 0; i < lu_dp; i++) begin
			// Live slot with base done or x0
			lu_ready[i] = malloc[i] & (rf_done[i] | is_x0(slots[i].rs1));
			// Signed and unsigned forms share a size bit
			lu_param[i].size.b = slots[i].lb | slots[i].lbu;
			lu_param[i].size.h = slots[i].lh | slots[i].lhu;
			lu_param[i].size.w = slots[i].lw | slots[i].lwu;
			lu_param[i].size.d = slots[i].ld;
			lu_param[i].rd = slots[i].rd;
			lu_param[i].addr = rf_data[i] + slots[i].imm;
			lu_param[i].usi = slots[i].lbu | slots[i].lhu | slots[i].lwu;
		end
	end

	// Lowest ready slot goes first
	first_clear_select #(
		.width(lu_dp)
	) u_pick (
		.req(lu_ready),
		.pos(lu_pop_index),
		.any(lu_any)
	);

	// Slot leaves in the edge that loads the output
	assign lu_pop = lu_exeparam_ready & lu_any & ~flush;

	// Load valid holds while ready is low
	always_ff @(posedge CLK) begin
		if (rst | flush) begin
			lu_exeparam_valid <= 1'b0;
		end else if (lu_exeparam_ready) begin
			lu_exeparam_valid <= lu_any;
		end
	end

	always_ff @(posedge CLK) begin
		if (lu_pop) begin
			lu_exeparam <= lu_param[lu_pop_index];
		end
	end

	// Store head operand checks
	assign su_rs1_ok = rf_done[su_rs1_port] | is_x0(su_head.rs1);
	assign su_rs2_ok = rf_done[su_rs2_port] | is_x0(su_head.rs2);
	assign su_clear = ~su_empty & su_rs1_ok & su_rs2_ok;

	// Head leaves only with commit permission and a ready executor
	assign su_pop = su_clear & su_exeparam_ready & commit_store_ready & ~flush;

	// One-cycle pulse per issued store
	always_ff @(posedge CLK) begin
		if (rst) begin
			su_exeparam_valid <= 1'b0;
		end else begin
			su_exeparam_valid <= su_pop;
		end
	end

	// Data holds between pulses
	always_ff @(posedge CLK) begin
		if (su_pop) begin
			su_exeparam.size <= su_head.op;
			su_exeparam.addr <= rf_data[su_rs1_port] + su_head.imm;
			su_exeparam.data <= rf_data[su_rs2_port];
		end
	end

endmodule

//--- logic/lsu_issue_top.sv
// Dispatch is four-phase and one per handshake; a dispatch is held off during flush
`timescale 1ns/1ns

module lsu_issue_top (
	input  logic CLK,
	input  logic rst,
	input  logic flush,
	input  logic dispatch_req,
	input  lsu_pkg::dispatch_t dispatch,
	output logic dispatch_ack,
	input  logic wb_valid,
	input  lsu_pkg::wb_t wb,
	input  logic commit_store_ready,
	input  logic lu_exeparam_ready,
	output logic lu_exeparam_valid,
	output lsu_pkg::lu_exeparam_t lu_exeparam,
	input  logic su_exeparam_ready,
	output logic su_exeparam_valid,
	output lsu_pkg::su_exeparam_t su_exeparam
);
	import lsu_pkg::*;

	logic lu_full;
	logic su_full;
	logic su_empty;
	logic space;
	logic accept;
	logic lu_push;
	logic su_push;
	logic lu_pop;
	logic su_pop;
	logic [lu_iw-1:0] lu_pop_index;
	logic [lu_dp-1:0] malloc;
	lu_info_t [lu_dp-1:0] slots;
	su_info_t su_head;
	logic [rp_num-1:0][preg_w-1:0] rf_idx;
	logic [rp_num-1:0][xlen-1:0] rf_data;
	logic [rp_num-1:0] rf_done;

	// Room in whichever queue the word targets
	assign space = dispatch.is_store ? ~su_full : ~lu_full;
	// New request only, not one already acked
	assign accept = dispatch_req & ~dispatch_ack & space & ~flush;
	assign lu_push = accept & ~dispatch.is_store;
	assign su_push = accept & dispatch.is_store;

	// Ack rises with the write, falls the cycle after req drops
	always_ff @(posedge CLK) begin
		if (rst) begin
			dispatch_ack <= 1'b0;
		end else if (dispatch_ack) begin
			dispatch_ack <= dispatch_req;
		end else begin
			dispatch_ack <= accept;
		end
	end

	phy_regfile u_regfile (
		.CLK(CLK), .rst(rst), .wb_valid(wb_valid), .wb(wb),
		.alloc_valid(lu_push), .alloc_preg(dispatch.info.lu.rd),
		.rd_idx(rf_idx), .rd_data(rf_data), .rd_done(rf_done)
	);

	lu_issue_buffer u_lu_buf (
		.CLK(CLK), .rst(rst), .flush(flush), .push(lu_push), .push_info(dispatch.info.lu),
		.pop(lu_pop), .pop_index(lu_pop_index), .malloc(malloc), .slots(slots), .full(lu_full)
	);

	su_issue_fifo u_su_fifo (
		.CLK(CLK), .rst(rst), .flush(flush), .push(su_push), .push_info(dispatch.info.su),
		.pop(su_pop), .head(su_head), .empty(su_empty), .full(su_full)
	);

	lsu_issue u_issue (
		.CLK(CLK), .rst(rst), .flush(flush), .malloc(malloc), .slots(slots),
		.su_head(su_head), .su_empty(su_empty), .rf_data(rf_data), .rf_done(rf_done),
		.lu_exeparam_ready(lu_exeparam_ready), .su_exeparam_ready(su_exeparam_ready),
		.commit_store_ready(commit_store_ready), .rf_idx(rf_idx),
		.lu_pop(lu_pop), .lu_pop_index(lu_pop_index),
		.lu_exeparam_valid(lu_exeparam_valid), .lu_exeparam(lu_exeparam),
		.su_pop(su_pop), .su_exeparam_valid(su_exeparam_valid), .su_exeparam(su_exeparam)
	);

endmodule

//--- dv/lsu_issue_asserts.sv
// Bound into lsu_issue_top; checks only the dispatch handshake and load output hold
`timescale 1ns/1ns

module lsu_issue_asserts (
	input  logic CLK,
	input  logic rst,
	input  logic flush,
	input  logic dispatch_req,
	input  logic dispatch_ack,
	input  logic lu_exeparam_valid,
	input  logic lu_exeparam_ready,
	input  lsu_pkg::lu_exeparam_t lu_exeparam
);

	// Ack only answers a request
	a_ack_after_req: assert property (@(posedge CLK) disable iff (rst)
		$rose(dispatch_ack) |-> $past(dispatch_req))
		else $error("dispatch ack rose without a pending request");

	// Ack drops once the request is gone
	a_ack_falls: assert property (@(posedge CLK) disable iff (rst)
		(dispatch_ack && !dispatch_req) |=> !dispatch_ack)
		else $error("dispatch ack stayed high after the request fell");

	// Stalled load output holds
	a_lu_hold: assert property (@(posedge CLK) disable iff (rst || flush)
		(lu_exeparam_valid && !lu_exeparam_ready) |=> (lu_exeparam_valid && $stable(lu_exeparam)))
		else $error("load output changed while the executor stalled it");

endmodule

bind lsu_issue_top lsu_issue_asserts u_asserts (
	.CLK(CLK), .rst(rst), .flush(flush), .dispatch_req(dispatch_req),
	.dispatch_ack(dispatch_ack), .lu_exeparam_valid(lu_exeparam_valid),
	.lu_exeparam_ready(lu_exeparam_ready), .lu_exeparam(lu_exeparam)
);

//--- dv/lsu_issue_tb.sv
// Runs dv/lsu_testdata.txt from the project root; load rd values must be unique per test
`timescale 1ns/1ns

module lsu_issue_tb;
	import lsu_pkg::*;

	logic CLK;
	logic rst;
	logic flush;
	logic dispatch_req;
	logic dispatch_ack;
	dispatch_t dispatch;
	logic wb_valid;
	wb_t wb;
	logic commit_store_ready;
	logic lu_exeparam_ready;
	logic lu_exeparam_valid;
	lu_exeparam_t lu_exeparam;
	logic su_exeparam_ready;
	logic su_exeparam_valid;
	su_exeparam_t su_exeparam;

	string test_name = "none";
	int errors = 0;
	int checks = 0;
	int n_lines = 0;
	logic [31:0] lfsr_state = 32'hff88_694a;
	string lines[$];
	// Dispatches still in flight, head is on the port
	dispatch_t disp_q[$];
	// Loads keyed by rd, stores in order
	lu_exeparam_t exp_lu[int];
	su_exeparam_t exp_su[$];
	// Store sizes in dispatch order, taken by the next expected store
	mem_size_t st_size[$];
	// Commit and executor ready as the DUT saw them one edge back
	logic su_allowed = 1'b0;

	lsu_issue_top dut (
		.CLK(CLK), .rst(rst), .flush(flush), .dispatch_req(dispatch_req),
		.dispatch(dispatch), .dispatch_ack(dispatch_ack), .wb_valid(wb_valid), .wb(wb),
		.commit_store_ready(commit_store_ready), .lu_exeparam_ready(lu_exeparam_ready),
		.lu_exeparam_valid(lu_exeparam_valid), .lu_exeparam(lu_exeparam),
		.su_exeparam_ready(su_exeparam_ready), .su_exeparam_valid(su_exeparam_valid),
		.su_exeparam(su_exeparam)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// Op codes 0..6 are lb lh lw ld lbu lhu lwu
	function automatic dispatch_t build_load(input logic [63:0] op, input logic [63:0] rd,
		input logic [63:0] rs1, input logic [63:0] imm);
		dispatch_t d;
		d = '0;
		case (op)
			0: d.info.lu.lb = 1'b1;
			1: d.info.lu.lh = 1'b1;
			2: d.info.lu.lw = 1'b1;
			3: d.info.lu.ld = 1'b1;
			4: d.info.lu.lbu = 1'b1;
			5: d.info.lu.lhu = 1'b1;
			default: d.info.lu.lwu = 1'b1;
		endcase
		d.info.lu.rd = rd[preg_w-1:0];
		d.info.lu.rs1 = rs1[preg_w-1:0];
		d.info.lu.imm = imm;
		return d;
	endfunction

	// Op codes 0..3 are sb sh sw sd
	function automatic dispatch_t build_store(input logic [63:0] op, input logic [63:0] rs1,
		input logic [63:0] rs2, input logic [63:0] imm);
		dispatch_t d;
		d = '0;
		d.is_store = 1'b1;
		d.info.su.op = mem_size_t'(4'b1000 >> op[1:0]);
		d.info.su.rs1 = rs1[preg_w-1:0];
		d.info.su.rs2 = rs2[preg_w-1:0];
		d.info.su.imm = imm;
		return d;
	endfunction

	// Executor readiness, one LFSR step per bit
	always @(posedge CLK) begin
		lu_exeparam_ready <= lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
		su_exeparam_ready <= lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	end

	// Four-phase dispatch driver
	initial begin
		forever begin
			while (disp_q.size() == 0) @(posedge CLK);
			dispatch_req <= 1'b1;
			dispatch <= disp_q[0];
			do @(posedge CLK); while (!dispatch_ack);
			dispatch_req <= 1'b0;
			do @(posedge CLK); while (dispatch_ack);
			void'(disp_q.pop_front());
		end
	end

	// Result collection
	always @(posedge CLK) begin
		if (!rst && lu_exeparam_valid && lu_exeparam_ready) begin
			if (exp_lu.exists(int'(lu_exeparam.rd))) begin
				check("load addr", exp_lu[int'(lu_exeparam.rd)].addr, lu_exeparam.addr);
				check("load size", 64'(exp_lu[int'(lu_exeparam.rd)].size), 64'(lu_exeparam.size));
				check("load unsigned", 64'(exp_lu[int'(lu_exeparam.rd)].usi), 64'(lu_exeparam.usi));
				exp_lu.delete(int'(lu_exeparam.rd));
			end else begin
				errors++;
				$display("error in %s: unexpected load result for rd %h", test_name, lu_exeparam.rd);
			end
		end
		// Store pulse only after a cycle with commit and a ready executor
		if (!rst && su_exeparam_valid && !su_allowed) begin
			errors++;
			$display("error in %s: store issued without commit permission or a ready executor",
				test_name);
		end
		su_allowed = commit_store_ready && su_exeparam_ready;
		if (!rst && su_exeparam_valid) begin
			if (exp_su.size() != 0) begin
				check("store addr", exp_su[0].addr, su_exeparam.addr);
				check("store data", exp_su[0].data, su_exeparam.data);
				check("store size", 64'(exp_su[0].size), 64'(su_exeparam.size));
				void'(exp_su.pop_front());
			end else begin
				errors++;
				$display("error in %s: unexpected store issued to %h", test_name, su_exeparam.addr);
			end
		end
	end

	task automatic wait_results();
		while (exp_lu.num() != 0 || exp_su.size() != 0) @(posedge CLK);
	endtask

	task automatic run_line(input string line);
		string cmd;
		string name;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		logic [63:0] d;
		lu_exeparam_t el;
		su_exeparam_t es;
		int n;
		a = '0;
		b = '0;
		c = '0;
		d = '0;
		n = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
		case (cmd)
			"T": begin
				n = $sscanf(line, "%s %s", cmd, name);
				test_name = name;
			end
			"W": begin
				wb_valid <= 1'b1;
				wb.idx <= a[preg_w-1:0];
				wb.data <= b;
				@(posedge CLK);
				wb_valid <= 1'b0;
				@(posedge CLK);
			end
			"L": disp_q.push_back(build_load(a, b, c, d));
			"S": begin
				disp_q.push_back(build_store(a, b, c, d));
				// sb sh sw sd give size b h w d
				st_size.push_back(mem_size_t'(4'b1000 >> a[1:0]));
			end
			"E": begin
				el.rd = a[preg_w-1:0];
				el.addr = b;
				el.size = mem_size_t'(c[3:0]);
				el.usi = d[0];
				exp_lu[int'(a)] = el;
			end
			"X": begin
				es = '0;
				es.addr = a;
				es.data = b;
				if (st_size.size() != 0)
					es.size = st_size.pop_front();
				exp_su.push_back(es);
			end
			"C": begin
				commit_store_ready <= a[0];
				@(posedge CLK);
			end
			"F": begin
				// Queued stores are dropped by the flush
				st_size.delete();
				flush <= 1'b1;
				@(posedge CLK);
				flush <= 1'b0;
				@(posedge CLK);
			end
			"R": wait_results();
			"D": while (disp_q.size() != 0) @(posedge CLK);
			"P": repeat (int'(a)) @(posedge CLK);
			"B": check("dispatches held off", 64'd1, 64'(disp_q.size()));
			default: begin
				errors++;
				$display("error: unknown command in test data: %s", line);
			end
		endcase
	endtask

	initial begin
		int fd;
		string line;
		rst = 1'b1;
		flush = 1'b0;
		dispatch_req = 1'b0;
		dispatch = '0;
		wb_valid = 1'b0;
		wb = '0;
		commit_store_ready = 1'b0;
		lu_exeparam_ready = 1'b0;
		su_exeparam_ready = 1'b0;
		fd = $fopen("dv/lsu_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("error: cannot open the test data file");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		n_lines = lines.size();
		repeat (5) @(posedge CLK);
		rst <= 1'b0;
		@(posedge CLK);
		foreach (lines[i]) run_line(lines[i]);
		wait_results();
		repeat (10) @(posedge CLK);
		if (checks == 0) begin
			errors++;
			$display("error: no checks were run");
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog, 200 cycles per data line
	initial begin
		while (n_lines == 0) @(posedge CLK);
		repeat (n_lines * 200) @(posedge CLK);
		$display("error: timeout in test %s, a result or dispatch ack never came", test_name);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- lsu_issue_sys.f
logic/lsu_pkg.sv
logic/first_clear_select.sv
logic/phy_regfile.sv
logic/lu_issue_buffer.sv
logic/su_issue_fifo.sv
logic/lsu_issue.sv
logic/lsu_issue_top.sv
dv/lsu_issue_asserts.sv
dv/lsu_issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsu_issue_sys.f --top-module lsu_issue_tb -o sim_lsu
./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	exit 1
fi

//--- dv/lsu_testdata.txt
# T name | W preg value | L op rd rs1 imm | S op rs1 rs2 imm | E rd addr size usi | X addr data
# C commit | F flush | R wait results | D wait dispatch | P cycles | B fifth dispatch held off
T ready_loads
W 04 1000
W 06 2000
L 5 0a 04 10
L 0 0b 06 8
L 3 0c 04 fffffffffffffff0
L 6 0d 06 4
E 0a 1010 4 1
E 0b 2008 8 0
E 0c ff0 1 0
E 0d 2004 2 1
R
T out_of_order
L 2 14 00 100
E 14 100 2 0
D
L 3 15 14 8
L 1 16 04 20
E 16 1020 4 0
R
E 15 5008 1 0
W 14 5000
R
T x0_base
C 1
L 4 17 01 7ff
E 17 7ff 8 1
S 3 00 06 40
X 40 2000
R
T store_order
C 0
L 3 18 00 0
E 18 0 1 0
R
S 3 04 18 8
S 2 06 04 c
D
P 30
X 1008 abcd
X 200c 1000
C 1
P 30
W 18 abcd
R
T queue_full
L 0 19 00 0
E 19 0 8 0
R
L 2 1a 19 0
L 3 1b 19 4
L 1 1c 19 8
L 4 1d 19 c
L 6 1e 19 10
P 40
B
E 1a 3000 2 0
E 1b 3004 1 0
E 1c 3008 4 0
E 1d 300c 8 1
E 1e 3010 2 1
W 19 3000
R
T flush
L 0 1f 00 0
E 1f 0 8 0
R
L 3 20 1f 0
S 0 1f 04 0
D
F
W 1f 7
P 30
L 3 21 04 8
E 21 1008 1 0
S 1 04 06 2
X 1002 2000
R
